// ==== source/vp_consts.svh ====
////////////////////////////////////////////////////////////
// Divider limits, store sizes, cartridge image sizes
// and download indices of the board glue
////////////////////////////////////////////////////////////
`ifndef VP_CONSTS_SVH
`define VP_CONSTS_SVH

// Enable counter limits, period is limit plus one
`define VP_CPU_DIV_NTSC 7
`define VP_CPU_DIV_PAL  11
`define VP_VDC_DIV_NTSC 5
`define VP_VDC_DIV_PAL  9

`define VP_ROM_DEPTH  16384 // Program store bytes
`define VP_CHAR_DEPTH 512   // Font store bytes

`define VP_CART_4K  4096
`define VP_CART_8K  8192
`define VP_CART_16K 16384   // 12K images banked as 16K

`define VP_IDX_CART 1
`define VP_IDX_XROM 2
`define VP_IDX_FONT 3
`endif

// ==== source/vp_pkg.sv ====
////////////////////////////////////////////////////////////
// Vector types shared by the board glue and its bench
////////////////////////////////////////////////////////////
package vp_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [11:0] cart_addr_t;  // Core side cartridge address
	typedef logic [13:0] rom_addr_t;   // 16 KiB program store
	typedef logic [8:0]  char_addr_t;  // 512 byte font store
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [15:0] size_t;       // Downloaded byte count

	// Joypad word
	// 0 right, 1 left, 2 down, 3 up, 4 action, 5 reset
	// 6..15 number keys 1..9 then 0
	typedef logic [15:0] joy_t;
	typedef logic [9:0]  numpad_t;

	// Bit 10 toggles per event, bit 9 pressed, 8..0 scan code
	typedef logic [10:0] ps2_key_t;

	typedef logic [2:0]  contrast_t;
	typedef logic [23:0] rgb_t;        // R in 23..16, B in 7..0
	typedef logic [1:0]  pair_t;       // Bit 1 joystick A, bit 0 joystick B

endpackage

// ==== source/vp_clock_enables.sv ====
////////////////////////////////////////////////////////////
// CPU and VDC clock enable pulses, NTSC and PAL
////////////////////////////////////////////////////////////
`include "vp_consts.svh"

module vp_clock_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,     // Only changes while reset is held
	output logic cpu_en_o,
	output logic vdc_en_o
);

	logic [3:0] cpu_ctr;
	logic [3:0] vdc_ctr;
	logic [3:0] cpu_limit;
	logic [3:0] vdc_limit;

	assign cpu_limit = pal_i ? 4'(`VP_CPU_DIV_PAL) : 4'(`VP_CPU_DIV_NTSC);
	assign vdc_limit = pal_i ? 4'(`VP_VDC_DIV_PAL) : 4'(`VP_VDC_DIV_NTSC);

	// CPU divider, 8 or 12 cycles
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_ctr  <= 4'd0;
			cpu_en_o <= 1'b0;
		end else if (cpu_ctr >= cpu_limit) begin
			cpu_ctr  <= 4'd0;
			cpu_en_o <= 1'b1;   // Pulse on the wrap edge
		end else begin
			cpu_ctr  <= cpu_ctr + 4'd1;
			cpu_en_o <= 1'b0;
		end
	end

	// VDC divider, 6 or 10 cycles
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vdc_ctr  <= 4'd0;
			vdc_en_o <= 1'b0;
		end else if (vdc_ctr >= vdc_limit) begin
			vdc_ctr  <= 4'd0;
			vdc_en_o <= 1'b1;
		end else begin
			vdc_ctr  <= vdc_ctr + 4'd1;
			vdc_en_o <= 1'b0;
		end
	end

endmodule

// ==== source/vp_rom_store.sv ====
////////////////////////////////////////////////////////////
// Download tracking, cartridge bank mapping,
// program store and font store
////////////////////////////////////////////////////////////
`include "vp_consts.svh"

module vp_rom_store (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_active_i,
	input  logic                  dl_wr_i,
	input  vp_pkg::dl_index_t     dl_index_i,
	input  vp_pkg::dl_addr_t      dl_addr_i,
	input  vp_pkg::byte_t         dl_data_i,
	input  vp_pkg::cart_addr_t    cart_addr_i,
	input  logic                  cart_bs0_i,
	input  logic                  cart_bs1_i,
	input  logic                  cart_rd_n_i,
	input  logic                  cart_cs_n_i,
	input  vp_pkg::char_addr_t    char_addr_i,
	input  logic                  char_en_i,
	output vp_pkg::byte_t         cart_data_o,
	output vp_pkg::byte_t         char_data_o
);

	vp_pkg::byte_t     prog_mem [`VP_ROM_DEPTH];
	vp_pkg::byte_t     char_mem [`VP_CHAR_DEPTH];

	logic              dl_active_q;
	logic              xrom;
	vp_pkg::size_t     cart_size;
	vp_pkg::rom_addr_t rom_addr;
	logic              prog_we;
	logic              char_we;
	logic              rom_rd_en;

	////////////////////////////////////////////////////////////
	// Download bookkeeping

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			xrom        <= 1'b0;
			cart_size   <= '0;
		end else begin
			dl_active_q <= dl_active_i;
			if (dl_active_i && !dl_active_q) begin  // Start of a new image
				cart_size <= '0;
				xrom      <= (dl_index_i == vp_pkg::dl_index_t'(`VP_IDX_XROM));
			end else if (dl_active_i && dl_wr_i) begin
				cart_size <= cart_size + 16'd1;
			end
		end
	end

	assign prog_we = dl_active_i && dl_wr_i &&
		(dl_index_i == vp_pkg::dl_index_t'(`VP_IDX_CART) ||
		 dl_index_i == vp_pkg::dl_index_t'(`VP_IDX_XROM));
	assign char_we = dl_active_i && dl_wr_i &&
		(dl_index_i == vp_pkg::dl_index_t'(`VP_IDX_FONT));

	////////////////////////////////////////////////////////////
	// Bank mapping of the core address

	always_comb begin
		if (xrom) begin
			rom_addr = {2'b00, cart_addr_i};
		end else begin
			case (cart_size)
				16'(`VP_CART_4K):  rom_addr = {2'b00, cart_bs0_i, cart_addr_i[11],
				                               cart_addr_i[9:0]};
				16'(`VP_CART_8K):  rom_addr = {1'b0, cart_bs1_i, cart_bs0_i, cart_addr_i[11],
				                               cart_addr_i[9:0]};
				16'(`VP_CART_16K): rom_addr = {cart_bs1_i, cart_bs0_i, cart_addr_i};
				default:           rom_addr = {3'b000, cart_addr_i[11], cart_addr_i[9:0]};
			endcase
		end
	end

	// XROM is read with PSEN high outside the bank0 chip select window
	assign rom_rd_en = xrom ? (cart_rd_n_i && !(cart_cs_n_i && cart_bs0_i)) : !cart_rd_n_i;

	////////////////////////////////////////////////////////////
	// Stores

	always_ff @(posedge clk_sys) begin
		if (prog_we)
			prog_mem[dl_addr_i[13:0]] <= dl_data_i;
		if (char_we)
			char_mem[dl_addr_i[8:0]] <= dl_data_i;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cart_data_o <= '0;
			char_data_o <= '0;
		end else begin
			if (rom_rd_en)
				cart_data_o <= prog_mem[rom_addr];  // Holds otherwise
			if (char_en_i)
				char_data_o <= char_mem[char_addr_i];
		end
	end

endmodule

// ==== source/vp_input_ctrl.sv ====
////////////////////////////////////////////////////////////
// Joystick swap and direction lines, PS/2 and number pad
// key events for the core keymap
////////////////////////////////////////////////////////////
module vp_input_ctrl (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              swap_i,
	input  vp_pkg::joy_t      joy0_i,
	input  vp_pkg::joy_t      joy1_i,
	input  vp_pkg::ps2_key_t  ps2_key_i,
	output vp_pkg::pair_t     joy_up_n_o,
	output vp_pkg::pair_t     joy_down_n_o,
	output vp_pkg::pair_t     joy_left_n_o,
	output vp_pkg::pair_t     joy_right_n_o,
	output vp_pkg::pair_t     joy_action_n_o,
	output logic              joy_reset_n_o,
	output logic              key_ready_o,
	output logic              key_released_o,
	output vp_pkg::byte_t     key_ascii_o
);

	vp_pkg::joy_t    joy_a;
	vp_pkg::joy_t    joy_b;
	vp_pkg::numpad_t numpad;
	vp_pkg::numpad_t numpad_q;
	logic            ps2_toggle_q;
	logic            ps2_event;
	logic            ps2_changed;
	logic            ps2_released;
	logic            joy_changed;
	logic            joy_released;
	vp_pkg::byte_t   ps2_ascii;
	vp_pkg::byte_t   joy_ascii;

	// Scan code to ASCII, extended bit ignored
	function automatic vp_pkg::byte_t scan_to_ascii(input logic [7:0] code);
		case (code)
			8'h16: return "1";  8'h1E: return "2";  8'h26: return "3";
			8'h25: return "4";  8'h2E: return "5";  8'h36: return "6";
			8'h3D: return "7";  8'h3E: return "8";  8'h46: return "9";
			8'h45: return "0";
			8'h1C: return "a";  8'h32: return "b";  8'h21: return "c";
			8'h23: return "d";  8'h24: return "e";  8'h2B: return "f";
			8'h34: return "g";  8'h33: return "h";  8'h43: return "i";
			8'h3B: return "j";  8'h42: return "k";  8'h4B: return "l";
			8'h3A: return "m";  8'h31: return "n";  8'h44: return "o";
			8'h4D: return "p";  8'h15: return "q";  8'h2D: return "r";
			8'h1B: return "s";  8'h2C: return "t";  8'h3C: return "u";
			8'h2A: return "v";  8'h1D: return "w";  8'h22: return "x";
			8'h35: return "y";  8'h1A: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7B: return "-";
			8'h7C: return "*";
			8'h4A: return "/";
			8'h55: return "=";
			8'h1F: return 8'h11;  // Yes key
			8'h27: return 8'h12;  // No key
			8'h5A: return 8'h0A;  // Enter
			8'h66: return 8'h08;  // Backspace
			default: return 8'h00;
		endcase
	endfunction

	// Lowest pressed number key wins
	function automatic vp_pkg::byte_t pad_to_ascii(input vp_pkg::numpad_t pad);
		vp_pkg::byte_t code;
		code = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (pad[i])
				code = (i == 9) ? 8'h30 : 8'(8'h31 + i);
		end
		return code;
	endfunction

	////////////////////////////////////////////////////////////
	// Joysticks, lines are low when pressed

	assign joy_a = swap_i ? joy1_i : joy0_i;
	assign joy_b = swap_i ? joy0_i : joy1_i;

	assign joy_right_n_o  = {~joy_a[0], ~joy_b[0]};
	assign joy_left_n_o   = {~joy_a[1], ~joy_b[1]};
	assign joy_down_n_o   = {~joy_a[2], ~joy_b[2]};
	assign joy_up_n_o     = {~joy_a[3], ~joy_b[3]};
	assign joy_action_n_o = {~joy_a[4], ~joy_b[4]};
	assign joy_reset_n_o  = ~(joy_a[5] & joy_b[5]);  // Both players must agree

	////////////////////////////////////////////////////////////
	// Key events

	assign numpad    = joy_a[15:6] | joy_b[15:6];
	assign ps2_event = (ps2_key_i[10] != ps2_toggle_q);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ps2_toggle_q <= 1'b0;
			numpad_q     <= '0;
			ps2_changed  <= 1'b0;
			ps2_released <= 1'b1;
			joy_changed  <= 1'b0;
			joy_released <= 1'b1;
			ps2_ascii    <= '0;
			joy_ascii    <= '0;
		end else begin
			ps2_toggle_q <= ps2_key_i[10];
			numpad_q     <= numpad;
			ps2_changed  <= ps2_event;
			joy_changed  <= (numpad != numpad_q);
			joy_released <= (numpad == '0);
			if (ps2_event) begin
				ps2_ascii    <= scan_to_ascii(ps2_key_i[7:0]);
				ps2_released <= ~ps2_key_i[9];
			end
			if (numpad != '0)
				joy_ascii <= pad_to_ascii(numpad);  // Last key held on release
		end
	end

	assign key_ready_o    = ps2_changed | joy_changed;
	assign key_ascii_o    = ps2_changed ? ps2_ascii : joy_ascii;
	assign key_released_o = ps2_released & joy_released;

endmodule

// ==== source/vp_palette.sv ====
////////////////////////////////////////////////////////////
// Calibrated palette with contrast variants
////////////////////////////////////////////////////////////
module vp_palette (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              pix_en_i,
	input  logic              r_i,
	input  logic              g_i,
	input  logic              b_i,
	input  logic              luma_i,
	input  vp_pkg::contrast_t contrast_i,
	output vp_pkg::rgb_t      rgb_o
);

	// Indexed by {r, g, b, luma}
	localparam vp_pkg::rgb_t PALETTE [16] = '{
		24'h000000, 24'h676767, 24'h1A37BE, 24'h5C80F6,  // Black, grey, blues
		24'h006D07, 24'h56C469, 24'h2AAABE, 24'h77E6EB,
		24'h790000, 24'hC75151, 24'h94309F, 24'hDC84E8,  // Reds, violets
		24'h77670B, 24'hC6B86A, 24'hCECECE, 24'hFFFFFF
	};

	vp_pkg::rgb_t  entry;
	vp_pkg::rgb_t  colour;
	vp_pkg::byte_t red;
	vp_pkg::byte_t green;
	vp_pkg::byte_t blue;

	assign entry = PALETTE[{r_i, g_i, b_i, luma_i}];
	assign red   = entry[23:16];
	assign green = entry[15:8];
	assign blue  = entry[7:0];

	// Mixed channels, blue output mirrors red
	always_comb begin
		case (contrast_i)
			3'd1: colour = {{red[7:1], blue[7]}, {green[7], red[7:1]}, {red[7:1], blue[7]}};
			3'd2: colour = {{red[7:2], blue[7:6]}, {green[7:6], red[7:2]},
			                {red[7:2], blue[7:6]}};
			3'd3: colour = {{red[7:4], blue[7:4]}, {green[7:4], red[7:4]},
			                {red[7:4], blue[7:4]}};
			3'd5: colour = {{blue[7:4], red[7:4]}, {green[7:4], blue[7:4]},
			                {blue[7:4], red[7:4]}};
			3'd6: colour = {{blue[7:2], red[7:6]}, {green[7:6], blue[7:2]},
			                {blue[7:2], red[7:6]}};
			3'd7: colour = {{blue[7:1], red[7]}, {green[7], blue[7:1]}, {blue[7:1], red[7]}};
			default: colour = entry;  // Modes 0 and 4
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			rgb_o <= '0;
		else if (pix_en_i)
			rgb_o <= colour;
	end

endmodule

// ==== source/vp_board.sv ====
////////////////////////////////////////////////////////////
// Board glue top level around the console core
////////////////////////////////////////////////////////////
module vp_board (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               pal_i,
	output logic               cpu_en_o,
	output logic               vdc_en_o,
	// Host download
	input  logic               dl_active_i,
	input  logic               dl_wr_i,
	input  vp_pkg::dl_index_t  dl_index_i,
	input  vp_pkg::dl_addr_t   dl_addr_i,
	input  vp_pkg::byte_t      dl_data_i,
	// Cartridge and font bus
	input  vp_pkg::cart_addr_t cart_addr_i,
	input  logic               cart_bs0_i,
	input  logic               cart_bs1_i,
	input  logic               cart_rd_n_i,
	input  logic               cart_cs_n_i,
	input  vp_pkg::char_addr_t char_addr_i,
	input  logic               char_en_i,
	output vp_pkg::byte_t      cart_data_o,
	output vp_pkg::byte_t      char_data_o,
	// Input devices
	input  logic               swap_i,
	input  vp_pkg::joy_t       joy0_i,
	input  vp_pkg::joy_t       joy1_i,
	input  vp_pkg::ps2_key_t   ps2_key_i,
	output vp_pkg::pair_t      joy_up_n_o,
	output vp_pkg::pair_t      joy_down_n_o,
	output vp_pkg::pair_t      joy_left_n_o,
	output vp_pkg::pair_t      joy_right_n_o,
	output vp_pkg::pair_t      joy_action_n_o,
	output logic               joy_reset_n_o,
	output logic               key_ready_o,
	output logic               key_released_o,
	output vp_pkg::byte_t      key_ascii_o,
	// Video
	input  logic               r_i,
	input  logic               g_i,
	input  logic               b_i,
	input  logic               luma_i,
	input  vp_pkg::contrast_t  contrast_i,
	output vp_pkg::rgb_t       rgb_o
);

	logic vdc_en;  // Also the pixel enable

	assign vdc_en_o = vdc_en;

	vp_clock_enables u_clk_en (.clk_sys, .reset, .pal_i, .cpu_en_o, .vdc_en_o(vdc_en));

	vp_rom_store u_rom (.clk_sys, .reset, .dl_active_i, .dl_wr_i, .dl_index_i, .dl_addr_i,
		.dl_data_i, .cart_addr_i, .cart_bs0_i, .cart_bs1_i, .cart_rd_n_i, .cart_cs_n_i,
		.char_addr_i, .char_en_i, .cart_data_o, .char_data_o);

	vp_input_ctrl u_input (.clk_sys, .reset, .swap_i, .joy0_i, .joy1_i, .ps2_key_i,
		.joy_up_n_o, .joy_down_n_o, .joy_left_n_o, .joy_right_n_o, .joy_action_n_o,
		.joy_reset_n_o, .key_ready_o, .key_released_o, .key_ascii_o);

	vp_palette u_palette (.clk_sys, .reset, .pix_en_i(vdc_en), .r_i, .g_i, .b_i, .luma_i,
		.contrast_i, .rgb_o);

endmodule

// ==== bench/vp_board_asserts.sv ====
////////////////////////////////////////////////////////////
// Enable pulse and cartridge read checks on the top level
////////////////////////////////////////////////////////////
`include "vp_consts.svh"

module vp_board_asserts (
	input logic          clk_sys,
	input logic          reset,
	input logic          pal_i,
	input logic          cpu_en_o,
	input logic          vdc_en_o,
	input logic          dl_active_i,
	input logic          rd_en_i,
	input vp_pkg::byte_t cart_data_o
);
	timeunit 1ns;
	timeprecision 1ps;

	logic loaded;  // An image went into the store

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			loaded <= 1'b0;
		else if (dl_active_i)
			loaded <= 1'b1;
	end

	cpu_single: assert property (@(posedge clk_sys) disable iff (reset) cpu_en_o |=> !cpu_en_o);
	vdc_single: assert property (@(posedge clk_sys) disable iff (reset) vdc_en_o |=> !vdc_en_o);

	// Quiet gap of period minus one cycles
	cpu_gap_ntsc: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_o && !pal_i |=> !cpu_en_o [*`VP_CPU_DIV_NTSC]);
	cpu_gap_pal: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_o && pal_i |=> !cpu_en_o [*`VP_CPU_DIV_PAL]);

	cart_known: assert property (@(posedge clk_sys) disable iff (reset)
		loaded && !dl_active_i && rd_en_i |=> !$isunknown(cart_data_o));

endmodule

bind vp_board vp_board_asserts u_asserts (.clk_sys, .reset, .pal_i, .cpu_en_o, .vdc_en_o,
	.dl_active_i, .rd_en_i(u_rom.rom_rd_en), .cart_data_o);

// ==== bench/vp_board_tb.sv ====
////////////////////////////////////////////////////////////
// Directed tests of the board glue, watchdog, result line
////////////////////////////////////////////////////////////
`include "vp_consts.svh"

module vp_board_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// Download cycles, palette waits, then margin for the short tests
	localparam int BUDGET = 4096 + 8192 + 16384 + 4096 + 512 + 128 * 12 + 2000;

	localparam vp_pkg::rgb_t PAL_TABLE [16] = '{
		24'h000000, 24'h676767, 24'h1A37BE, 24'h5C80F6, 24'h006D07, 24'h56C469, 24'h2AAABE,
		24'h77E6EB, 24'h790000, 24'hC75151, 24'h94309F, 24'hDC84E8, 24'h77670B, 24'hC6B86A,
		24'hCECECE, 24'hFFFFFF
	};
	// Digits, letters, symbols, then the four control keys
	localparam vp_pkg::byte_t SCAN [46] = '{
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45, 8'h1C, 8'h32,
		8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31,
		8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
		8'h29, 8'h79, 8'h7B, 8'h7C, 8'h4A, 8'h55, 8'h1F, 8'h27, 8'h5A, 8'h66
	};
	localparam vp_pkg::byte_t CTRL_CHARS [4] = '{8'h11, 8'h12, 8'h0A, 8'h08};

	logic clk_sys, reset, pal_i, cpu_en_o, vdc_en_o;
	logic dl_active_i, dl_wr_i;
	vp_pkg::dl_index_t dl_index_i;
	vp_pkg::dl_addr_t dl_addr_i;
	vp_pkg::byte_t dl_data_i, cart_data_o, char_data_o, key_ascii_o;
	vp_pkg::cart_addr_t cart_addr_i;
	logic cart_bs0_i, cart_bs1_i, cart_rd_n_i, cart_cs_n_i, char_en_i;
	vp_pkg::char_addr_t char_addr_i;
	logic swap_i, joy_reset_n_o, key_ready_o, key_released_o;
	vp_pkg::joy_t joy0_i, joy1_i;
	vp_pkg::ps2_key_t ps2_key_i;
	vp_pkg::pair_t joy_up_n_o, joy_down_n_o, joy_left_n_o, joy_right_n_o, joy_action_n_o;
	logic r_i, g_i, b_i, luma_i;
	vp_pkg::contrast_t contrast_i;
	vp_pkg::rgb_t rgb_o;

	vp_pkg::byte_t rom_model [`VP_ROM_DEPTH];
	vp_pkg::byte_t font_model [`VP_CHAR_DEPTH];
	vp_pkg::size_t dl_size = '0;   // Size and XROM flag of the last image
	logic xrom_model = 1'b0;
	int seed = 27;
	int errors = 0;
	int checks = 0;
	string key_chars = "1234567890abcdefghijklmnopqrstuvwxyz +-*/=";

	vp_board UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		#(BUDGET * 40);
		$display("Timeout after %0d cycles, the tests did not finish", BUDGET);
		$display("Result: FAILED");
		$finish;
	end

	task automatic compare(input string name, input logic [23:0] got, input logic [23:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Clock enables

	task automatic enable_timing(input logic pal, input int cpu_per, input int vdc_per);
		int cpu_last;
		int vdc_last;
		int vdc_count;
		cpu_last = 0;
		vdc_last = 0;
		vdc_count = 0;
		@(posedge clk_sys);
		reset <= 1'b1;
		pal_i <= pal;   // Only while reset is held
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		for (int n = 1; n <= 3 * cpu_per; n++) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			if (cpu_en_o) begin
				compare("cpu_en_o spacing", n - cpu_last, cpu_per);
				cpu_last = n;
			end
			if (vdc_en_o) begin
				compare("vdc_en_o spacing", n - vdc_last, vdc_per);
				vdc_last = n;
				vdc_count++;
			end
		end
		compare("cpu_en_o last pulse", cpu_last, 3 * cpu_per);
		compare("vdc_en_o pulse count", vdc_count, 3 * cpu_per / vdc_per);
	endtask

	////////////////////////////////////////////////////////////
	// Stores

	task automatic download(input int index, input int nbytes);
		vp_pkg::byte_t d;
		@(posedge clk_sys);
		dl_index_i  <= index;
		dl_active_i <= 1'b1;
		for (int i = 0; i < nbytes; i++) begin
			@(posedge clk_sys);
			d = $random(seed);
			dl_wr_i   <= 1'b1;
			dl_addr_i <= i;
			dl_data_i <= d;
			if (index == `VP_IDX_FONT)
				font_model[i] = d;
			else
				rom_model[i] = d;
		end
		@(posedge clk_sys);
		dl_wr_i     <= 1'b0;
		dl_active_i <= 1'b0;
		dl_size    = nbytes;
		xrom_model = (index == `VP_IDX_XROM);
	endtask

	function automatic int map_addr(input vp_pkg::cart_addr_t a, input logic bs0, input logic bs1);
		if (xrom_model)
			return a;
		case (dl_size)
			`VP_CART_4K:  return {bs0, a[11], a[9:0]};
			`VP_CART_8K:  return {bs1, bs0, a[11], a[9:0]};
			`VP_CART_16K: return {bs1, bs0, a};
			default:      return {a[11], a[9:0]};
		endcase
	endfunction

	task automatic cart_read(input vp_pkg::cart_addr_t a, input logic bs0, input logic bs1,
		input logic rd_n, input logic cs_n);
		vp_pkg::byte_t held;
		vp_pkg::byte_t expected;
		logic en;
		held = cart_data_o;
		en = xrom_model ? (rd_n && !(cs_n && bs0)) : !rd_n;
		expected = en ? rom_model[map_addr(a, bs0, bs1)] : held;
		@(posedge clk_sys);
		cart_addr_i <= a;
		cart_bs0_i  <= bs0;
		cart_bs1_i  <= bs1;
		cart_rd_n_i <= rd_n;
		cart_cs_n_i <= cs_n;
		@(negedge clk_sys);
		compare("cart_data_o before the read edge", cart_data_o, held);
		@(posedge clk_sys);
		{cart_bs0_i, cart_rd_n_i, cart_cs_n_i} <= 3'b111;  // Idle bus with no read in either mode
		@(negedge clk_sys);
		compare("cart_data_o", cart_data_o, expected);
	endtask

	task automatic bank_mapping();
		logic [15:0] r;
		for (int s = 0; s < 3; s++) begin
			download(`VP_IDX_CART, `VP_CART_4K << s);
			repeat (12) begin
				r = $random(seed);
				// Every mapping keeps the address inside its image
				cart_read(r[11:0], r[12], r[13], 1'b0, r[14]);
			end
		end
	endtask

	task automatic xrom_reads();
		logic [15:0] r;
		download(`VP_IDX_XROM, 4096);
		repeat (16) begin
			r = $random(seed);
			cart_read(r[11:0], r[12], r[13], r[14] | r[15], r[14]);
		end
	endtask

	task automatic font_reads();
		logic [15:0] r;
		vp_pkg::byte_t held;
		download(`VP_IDX_FONT, `VP_CHAR_DEPTH);
		repeat (12) begin
			r = $random(seed);
			held = char_data_o;
			@(posedge clk_sys);
			char_addr_i <= r[8:0];
			char_en_i   <= 1'b1;
			@(negedge clk_sys);
			compare("char_data_o before the read edge", char_data_o, held);
			@(posedge clk_sys);
			char_addr_i <= ~r[8:0];  // Another entry with the read disabled
			char_en_i   <= 1'b0;
			@(negedge clk_sys);
			compare("char_data_o", char_data_o, font_model[r[8:0]]);
			cart_read(r[11:0], r[12], r[13], 1'b0, 1'b1);  // Cartridge still intact
			compare("char_data_o while disabled", char_data_o, font_model[r[8:0]]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Key events and joystick lines

	task automatic expect_event(input vp_pkg::byte_t ascii, input logic released);
		int pulses;
		pulses = 0;
		for (int n = 0; n < 4; n++) begin
			@(negedge clk_sys);
			if (key_ready_o) begin
				pulses++;
				compare("key_ready_o delay", n, 1);
				compare("key_ascii_o", key_ascii_o, ascii);
				compare("key_released_o", key_released_o, released);
			end
		end
		compare("key_ready_o pulse count", pulses, 1);
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed,
		input vp_pkg::byte_t ascii);
		@(posedge clk_sys);
		ps2_key_i <= {~ps2_key_i[10], pressed, code};
		expect_event(ascii, !pressed);
	endtask

	task automatic ps2_keys();
		vp_pkg::byte_t ascii;
		for (int i = 0; i < 46; i++) begin
			ascii = (i < 42) ? key_chars[i] : CTRL_CHARS[i - 42];
			send_key({i[0], SCAN[i]}, 1'b1, ascii);  // Extended bit on odd entries
			send_key({i[0], SCAN[i]}, 1'b0, ascii);
		end
		send_key(9'h076, 1'b1, 8'h00);  // Not in the table
		send_key(9'h076, 1'b0, 8'h00);
	endtask

	task automatic joypad_lines();
		logic [11:0] r;
		logic [5:0] a;
		logic [5:0] b;
		vp_pkg::byte_t ascii;
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			a = i[3] ? r[11:6] : r[5:0];
			b = i[3] ? r[5:0] : r[11:6];
			@(posedge clk_sys);
			swap_i <= i[3];
			joy0_i <= r[5:0];
			joy1_i <= r[11:6];
			@(negedge clk_sys);
			compare("joy direction lines", {joy_up_n_o, joy_down_n_o, joy_left_n_o,
				joy_right_n_o, joy_action_n_o, joy_reset_n_o}, {~a[3], ~b[3], ~a[2], ~b[2],
				~a[1], ~b[1], ~a[0], ~b[0], ~a[4], ~b[4], ~(a[5] & b[5])});
		end
		// Key k on one pad beats key 0 on the other
		for (int k = 0; k < 10; k++) begin
			ascii = (k == 9) ? "0" : 8'("1" + k);
			@(posedge clk_sys);
			joy0_i <= k[0] ? 16'h8000 : (16'h0040 << k);
			joy1_i <= k[0] ? (16'h0040 << k) : 16'h8000;
			expect_event(ascii, 1'b0);
			@(posedge clk_sys);
			joy0_i <= '0;
			joy1_i <= '0;
			expect_event(ascii, 1'b1);  // Last key held on release
		end
	endtask

	////////////////////////////////////////////////////////////
	// Palette

	function automatic vp_pkg::rgb_t expected_colour(input int idx, input int mode);
		vp_pkg::rgb_t e;
		vp_pkg::byte_t keep;
		vp_pkg::byte_t mix;
		vp_pkg::byte_t out_r;
		int n;
		e = PAL_TABLE[idx];
		if (mode == 0 || mode == 4)
			return e;
		n     = (mode < 4) ? (1 << (mode - 1)) : (1 << (7 - mode));
		keep  = (mode < 4) ? e[23:16] : e[7:0];  // Red for 1..3, blue for 5..7
		mix   = (mode < 4) ? e[7:0] : e[23:16];
		out_r = (keep & (8'hFF << n)) | (mix >> (8 - n));
		return {out_r, (e[15:8] & (8'hFF << (8 - n))) | (keep >> n), out_r};
	endfunction

	task automatic palette_modes();
		for (int idx = 0; idx < 16; idx++) begin
			for (int mode = 0; mode < 8; mode++) begin
				@(posedge clk_sys);
				{r_i, g_i, b_i, luma_i} <= idx[3:0];
				contrast_i <= mode[2:0];
				@(negedge clk_sys);
				while (!vdc_en_o)
					@(negedge clk_sys);
				@(negedge clk_sys);  // Registered on the enabled edge
				compare("rgb_o", rgb_o, expected_colour(idx, mode));
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		pal_i = 1'b0;
		{dl_active_i, dl_wr_i, dl_index_i, dl_addr_i, dl_data_i} = '0;
		{cart_addr_i, cart_bs1_i, char_addr_i, char_en_i} = '0;
		{cart_bs0_i, cart_rd_n_i, cart_cs_n_i} = 3'b111;
		{swap_i, joy0_i, joy1_i, ps2_key_i} = '0;
		{r_i, g_i, b_i, luma_i, contrast_i} = '0;
		enable_timing(1'b0, 8, 6);
		enable_timing(1'b1, 12, 10);
		bank_mapping();
		xrom_reads();
		font_reads();
		ps2_keys();
		joypad_lines();
		palette_modes();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+source
source/vp_pkg.sv
source/vp_clock_enables.sv
source/vp_rom_store.sv
source/vp_input_ctrl.sv
source/vp_palette.sv
source/vp_board.sv
bench/vp_board_asserts.sv
bench/vp_board_tb.sv

// ==== Bender.yml ====
package:
  name: vp_board

export_include_dirs:
  - source

sources:
  - files:
      - source/vp_pkg.sv
      - source/vp_clock_enables.sv
      - source/vp_rom_store.sv
      - source/vp_input_ctrl.sv
      - source/vp_palette.sv
      - source/vp_board.sv
  - target: test
    files:
      - bench/vp_board_asserts.sv
      - bench/vp_board_tb.sv
